/* hw/mouse_pkg.sv */
`default_nettype none

package mouse_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;    // data and address
  typedef logic [4:0]  reg_idx_t; // gpr index
  typedef logic [4:0]  opcode_t;  // inst[6:2], low bits always 2'b11
  typedef logic [2:0]  funct3_t;

  ////////////////////////////////////////////////////////////
  // opcode map, subset only
  ////////////////////////////////////////////////////////////

  localparam opcode_t OPC_LOAD   = 5'b00_000;
  localparam opcode_t OPC_OP_IMM = 5'b00_100;
  localparam opcode_t OPC_STORE  = 5'b01_000;
  localparam opcode_t OPC_OP     = 5'b01_100;
  localparam opcode_t OPC_LUI    = 5'b01_101;
  localparam opcode_t OPC_BRANCH = 5'b11_000;
  localparam opcode_t OPC_JAL    = 5'b11_011;
  localparam opcode_t OPC_SYSTEM = 5'b11_100; // ecall halts

  // alu funct3, R and I type
  localparam funct3_t F3_ADD  = 3'b000; // sub when funct7[5] on OP
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // branch funct3, bit 1 picks unsigned
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  ////////////////////////////////////////////////////////////
  // grouped signals
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        wen; // write enable
    word_t       adr; // byte address
    logic [3:0]  ben; // byte enables
    word_t       wdt; // write data
  } bus_req_t;

  typedef struct packed {
    opcode_t  opc;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    funct3_t  fn3;
    logic     alt; // funct7[5]
    word_t    imm; // sign extended, format picked by opcode
  } dec_t;

  typedef struct packed {
    word_t alu;  // selected alu result
    word_t sum;  // raw adder, also load/store address
    logic  take; // branch condition
  } exe_t;

  // core phases
  typedef enum logic [2:0] {
    ph_fetch,
    ph_rs1,
    ph_rs2,
    ph_exec,
    ph_halt
  } phase_t;

endpackage

`default_nettype wire

/* hw/mouse_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module mouse_decode (
  input  wire  mouse_pkg::word_t inw, // instruction word
  output var   mouse_pkg::dec_t  dec
);

  ////////////////////////////////////////////////////////////
  // immediate formats
  ////////////////////////////////////////////////////////////

  mouse_pkg::word_t imm_i; // alu imm, load
  mouse_pkg::word_t imm_s; // store
  mouse_pkg::word_t imm_b; // branch offset
  mouse_pkg::word_t imm_u; // lui
  mouse_pkg::word_t imm_j; // jal offset

  assign imm_i = {{21{inw[31]}}, inw[30:20]};
  assign imm_s = {{21{inw[31]}}, inw[30:25], inw[11:7]};
  assign imm_b = {{20{inw[31]}}, inw[7], inw[30:25], inw[11:8], 1'b0};
  assign imm_u = {inw[31:12], 12'd0};
  assign imm_j = {{12{inw[31]}}, inw[19:12], inw[20], inw[30:21], 1'b0};

  ////////////////////////////////////////////////////////////
  // fields
  ////////////////////////////////////////////////////////////

  always_comb begin
    dec.opc = inw[6:2];   // [1:0] ignored
    dec.rd  = inw[11:7];
    dec.rs1 = inw[19:15];
    dec.rs2 = inw[24:20];
    dec.fn3 = inw[14:12];
    dec.alt = inw[30];    // sub select
    // only the format of this opcode leaves the decoder
    case (inw[6:2])
      mouse_pkg::OPC_STORE:  dec.imm = imm_s;
      mouse_pkg::OPC_BRANCH: dec.imm = imm_b;
      mouse_pkg::OPC_LUI:    dec.imm = imm_u;
      mouse_pkg::OPC_JAL:    dec.imm = imm_j;
      default:               dec.imm = imm_i; // op_imm, load, system
    endcase
  end

endmodule

`default_nettype wire

/* hw/mouse_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module mouse_execute (
  input  wire  mouse_pkg::dec_t  dec,
  input  wire  mouse_pkg::word_t op1,
  input  wire  mouse_pkg::word_t op2,
  output var   mouse_pkg::exe_t  exe
);

  logic             is_bra;  // branch compare
  logic             is_alu;  // op or op_imm
  logic             sub;     // adder subtracts
  logic             sgn;     // signed compare
  logic [32:0]      add_a;
  logic [32:0]      add_b;
  logic [32:0]      add_s;   // bit 32 is the less-than flag when subtracting
  logic             lt;
  logic             eq;
  mouse_pkg::word_t log_out;
  mouse_pkg::word_t alu;
  logic             take;

  assign is_bra = dec.opc == mouse_pkg::OPC_BRANCH;
  assign is_alu = (dec.opc == mouse_pkg::OPC_OP) || (dec.opc == mouse_pkg::OPC_OP_IMM);

  // sub only on OP, addi with a negative imm has bit 30 set
  assign sub = is_bra | (is_alu & ((dec.fn3 == mouse_pkg::F3_SLT) |
                                   (dec.fn3 == mouse_pkg::F3_SLTU) |
                                   ((dec.fn3 == mouse_pkg::F3_ADD) & dec.alt &
                                    (dec.opc == mouse_pkg::OPC_OP))));
  assign sgn = is_bra ? ~dec.fn3[1] : (dec.fn3 == mouse_pkg::F3_SLT);

  ////////////////////////////////////////////////////////////
  // single 33 bit adder
  ////////////////////////////////////////////////////////////

  assign add_a = {sgn & op1[31], op1};                // sign or zero extend
  assign add_b = {sgn & op2[31], op2} ^ {33{sub}};    // invert for subtract
  assign add_s = add_a + add_b + {32'd0, sub};        // carry in completes negation
  assign lt    = add_s[32];
  assign eq    = add_s[31:0] == '0;

  assign log_out = (dec.fn3 == mouse_pkg::F3_XOR) ? (op1 ^ op2) :
                   (dec.fn3 == mouse_pkg::F3_OR)  ? (op1 | op2) :
                                                    (op1 & op2);

  always_comb begin
    case (dec.fn3)
      mouse_pkg::F3_SLT,
      mouse_pkg::F3_SLTU: alu = {31'd0, lt};
      mouse_pkg::F3_XOR,
      mouse_pkg::F3_OR,
      mouse_pkg::F3_AND:  alu = log_out;
      default:            alu = add_s[31:0]; // add, sub
    endcase
    case (dec.fn3)
      mouse_pkg::F3_BEQ:  take = eq;
      mouse_pkg::F3_BNE:  take = ~eq;
      mouse_pkg::F3_BLT,
      mouse_pkg::F3_BLTU: take = lt;
      mouse_pkg::F3_BGE,
      mouse_pkg::F3_BGEU: take = ~lt;
      default:            take = 1'b0;
    endcase
  end

  assign exe = '{alu: alu, sum: add_s[31:0], take: is_bra & take};

endmodule

`default_nettype wire

/* hw/mouse_result.sv */
`timescale 1ns/100ps
`default_nettype none

module mouse_result (
  input  wire  mouse_pkg::dec_t  dec,
  input  wire  mouse_pkg::exe_t  exe,
  input  wire  mouse_pkg::word_t pc,      // address of current instruction
  output var   mouse_pkg::word_t wb,      // write-back word
  output var   mouse_pkg::word_t pc_next
);

  mouse_pkg::word_t pc_inc; // sequential
  mouse_pkg::word_t pc_tgt; // jal and branch target
  logic             jump;

  assign pc_inc = pc + 32'd4;
  assign pc_tgt = pc + dec.imm;

  // jal always, branch only when its condition holds
  assign jump    = (dec.opc == mouse_pkg::OPC_JAL) | exe.take;
  assign pc_next = jump ? pc_tgt : pc_inc;

  ////////////////////////////////////////////////////////////
  // write-back select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (dec.opc)
      mouse_pkg::OPC_LUI: wb = dec.imm;  // upper imm as is
      mouse_pkg::OPC_JAL: wb = pc_inc;   // link
      default:            wb = exe.alu;  // load data muxed in the core
    endcase
  end

endmodule

`default_nettype wire

/* hw/mouse_core.sv */
`timescale 1ns/100ps
`default_nettype none

module mouse_core #(
  parameter mouse_pkg::word_t RST_ADR = 32'h0000_0000, // first fetch
  parameter mouse_pkg::word_t GPR_ADR = 32'h0000_0f80  // 128 byte aligned gpr base
)(
  input  wire                       clk,
  input  wire                       rst,
  output logic                      bus_vld,
  output var   mouse_pkg::bus_req_t bus_req,
  input  wire                       bus_rdy,
  input  wire  mouse_pkg::word_t    bus_rdt, // valid the cycle after a read
  output logic                      halted
);

  mouse_pkg::phase_t phase;
  mouse_pkg::phase_t phase_nxt;
  logic              run;      // low for the first cycle after reset
  logic              req_vld;  // phase wants a transfer
  logic              adv;      // phase completes this cycle
  logic              done;     // last phase of the instruction
  logic              use_rs2;
  mouse_pkg::word_t  pc;
  mouse_pkg::word_t  inw_buf;  // instruction word
  mouse_pkg::word_t  rs1_buf;  // rs1 value, needed after rs2 read
  mouse_pkg::word_t  inw;
  mouse_pkg::word_t  op1;
  mouse_pkg::word_t  op2;
  mouse_pkg::word_t  wb;
  mouse_pkg::word_t  pc_next;
  mouse_pkg::dec_t   dec;
  mouse_pkg::exe_t   exe;

  // register file word address
  function automatic mouse_pkg::word_t gpr_adr(input mouse_pkg::reg_idx_t idx);
    return {GPR_ADR[31:7], idx, 2'b00};
  endfunction

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  assign inw = (phase == mouse_pkg::ph_rs1) ? bus_rdt : inw_buf; // fresh fetch in rs1

  assign use_rs2 = (dec.opc == mouse_pkg::OPC_OP) || (dec.opc == mouse_pkg::OPC_BRANCH);
  assign op1     = (phase == mouse_pkg::ph_exec) ? rs1_buf : bus_rdt; // rs1 on bus in rs2 phase
  assign op2     = use_rs2 ? bus_rdt : dec.imm;

  mouse_decode u_dec (.inw(inw), .dec(dec));

  mouse_execute u_exe (.dec(dec), .op1(op1), .op2(op2), .exe(exe));

  mouse_result u_res (.dec(dec), .exe(exe), .pc(pc), .wb(wb), .pc_next(pc_next));

  ////////////////////////////////////////////////////////////
  // phase control and bus requests
  ////////////////////////////////////////////////////////////

  always_comb begin
    req_vld   = 1'b0;
    done      = 1'b0;
    phase_nxt = phase;
    bus_req   = '{wen: 1'b0, adr: pc, ben: 4'hf, wdt: '0}; // fetch by default
    case (phase)
      mouse_pkg::ph_fetch: begin
        req_vld   = 1'b1;
        phase_nxt = mouse_pkg::ph_rs1;
      end
      mouse_pkg::ph_rs1: begin
        case (dec.opc)
          mouse_pkg::OPC_LUI,
          mouse_pkg::OPC_JAL: begin
            req_vld   = dec.rd != '0; // x0 write skipped
            bus_req   = '{wen: 1'b1, adr: gpr_adr(dec.rd), ben: 4'hf, wdt: wb};
            phase_nxt = mouse_pkg::ph_fetch;
            done      = 1'b1;
          end
          mouse_pkg::OPC_SYSTEM: phase_nxt = mouse_pkg::ph_halt;
          default: begin
            req_vld   = 1'b1;
            bus_req   = '{wen: 1'b0, adr: gpr_adr(dec.rs1), ben: 4'hf, wdt: '0};
            phase_nxt = mouse_pkg::ph_rs2;
          end
        endcase
      end
      mouse_pkg::ph_rs2: begin
        phase_nxt = mouse_pkg::ph_exec;
        case (dec.opc)
          mouse_pkg::OPC_OP,
          mouse_pkg::OPC_STORE,
          mouse_pkg::OPC_BRANCH: begin
            req_vld = 1'b1;
            bus_req = '{wen: 1'b0, adr: gpr_adr(dec.rs2), ben: 4'hf, wdt: '0};
          end
          mouse_pkg::OPC_OP_IMM: begin
            req_vld   = dec.rd != '0;
            bus_req   = '{wen: 1'b1, adr: gpr_adr(dec.rd), ben: 4'hf, wdt: wb};
            phase_nxt = mouse_pkg::ph_fetch;
            done      = 1'b1;
          end
          mouse_pkg::OPC_LOAD: begin
            req_vld = 1'b1;
            bus_req = '{wen: 1'b0, adr: exe.sum, ben: 4'hf, wdt: '0}; // rs1+imm
          end
          default: begin // unsupported, step over
            phase_nxt = mouse_pkg::ph_fetch;
            done      = 1'b1;
          end
        endcase
      end
      mouse_pkg::ph_exec: begin
        phase_nxt = mouse_pkg::ph_fetch;
        done      = 1'b1;
        case (dec.opc)
          mouse_pkg::OPC_OP: begin
            req_vld = dec.rd != '0;
            bus_req = '{wen: 1'b1, adr: gpr_adr(dec.rd), ben: 4'hf, wdt: wb};
          end
          mouse_pkg::OPC_LOAD: begin
            req_vld = dec.rd != '0;
            bus_req = '{wen: 1'b1, adr: gpr_adr(dec.rd), ben: 4'hf, wdt: bus_rdt};
          end
          mouse_pkg::OPC_STORE: begin
            req_vld = 1'b1;
            bus_req = '{wen: 1'b1, adr: exe.sum, ben: 4'hf, wdt: bus_rdt}; // rs2 on bus
          end
          default: req_vld = 1'b0; // branch resolves without a transfer
        endcase
      end
      default: phase_nxt = mouse_pkg::ph_halt; // stays until reset
    endcase
  end

  assign bus_vld = run & req_vld;
  assign adv     = run & (~req_vld | bus_rdy); // wait out back-pressure
  assign halted  = phase == mouse_pkg::ph_halt;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run   <= 1'b0;
      phase <= mouse_pkg::ph_fetch;
      pc    <= RST_ADR;
    end else begin
      run <= 1'b1;
      if (adv) begin
        phase <= phase_nxt;
        if (done) pc <= pc_next; // instruction retires
      end
    end
  end

  // bus_rdt holds through stalls, each buffer follows it for its whole phase
  always_ff @(posedge clk) begin
    if (phase == mouse_pkg::ph_rs1) inw_buf <= bus_rdt;
    if (phase == mouse_pkg::ph_rs2) rs1_buf <= bus_rdt;
  end

endmodule

`default_nettype wire

/* hw/mouse_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module mouse_mem #(
  parameter int unsigned MEM_WORDS = 1024
)(
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       stall,   // throttles the core port
  input  wire                       bus_vld,
  input  wire  mouse_pkg::bus_req_t bus_req,
  output logic                      bus_rdy,
  output var   mouse_pkg::word_t    bus_rdt,
  input  wire                       dbg_vld, // always accepted
  input  wire  mouse_pkg::bus_req_t dbg_req,
  output var   mouse_pkg::word_t    dbg_rdt
);

  localparam int unsigned AW = $clog2(MEM_WORDS); // word index width

  mouse_pkg::word_t mem [MEM_WORDS];
  logic             bus_trn;
  logic [AW-1:0]    bus_idx;
  logic [AW-1:0]    dbg_idx;

  assign bus_rdy = ~stall;
  assign bus_trn = bus_vld & bus_rdy;
  assign bus_idx = bus_req.adr[AW+1:2]; // byte address to word
  assign dbg_idx = dbg_req.adr[AW+1:2];

  ////////////////////////////////////////////////////////////
  // byte-enabled writes, debug port last
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (bus_trn & bus_req.wen & bus_req.ben[b])
        mem[bus_idx][8*b +: 8] <= bus_req.wdt[8*b +: 8];
      if (dbg_vld & dbg_req.wen & dbg_req.ben[b])
        mem[dbg_idx][8*b +: 8] <= dbg_req.wdt[8*b +: 8];
    end
  end

  // read data held until the next read on the same port
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus_rdt <= '0;
      dbg_rdt <= '0;
    end else begin
      if (bus_trn & ~bus_req.wen) bus_rdt <= mem[bus_idx];
      if (dbg_vld & ~dbg_req.wen) dbg_rdt <= mem[dbg_idx];
    end
  end

endmodule

`default_nettype wire

/* hw/mouse_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mouse_top #(
  parameter mouse_pkg::word_t RST_ADR   = 32'h0000_0000, // program start
  parameter mouse_pkg::word_t GPR_ADR   = 32'h0000_0f80, // last 32 words
  parameter int unsigned      MEM_WORDS = 1024           // 4 KB
)(
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       stall,
  output logic                      halted,
  input  wire                       dbg_vld,
  input  wire  mouse_pkg::bus_req_t dbg_req,
  output var   mouse_pkg::word_t    dbg_rdt
);

  // shared system bus
  logic                bus_vld;
  mouse_pkg::bus_req_t bus_req;
  logic                bus_rdy;
  mouse_pkg::word_t    bus_rdt;

  mouse_core #(
    .RST_ADR (RST_ADR),
    .GPR_ADR (GPR_ADR)
  ) u_core (
    .clk     (clk),
    .rst     (rst),
    .bus_vld (bus_vld),
    .bus_req (bus_req),
    .bus_rdy (bus_rdy),
    .bus_rdt (bus_rdt),
    .halted  (halted)
  );

  mouse_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .bus_vld (bus_vld),
    .bus_req (bus_req),
    .bus_rdy (bus_rdy),
    .bus_rdt (bus_rdt),
    .dbg_vld (dbg_vld),
    .dbg_req (dbg_req),
    .dbg_rdt (dbg_rdt)
  );

endmodule

`default_nettype wire

/* verif/mouse_prog.svh */
`ifndef MOUSE_PROG_SVH
`define MOUSE_PROG_SVH

////////////////////////////////////////////////////////////
// program, loaded word by word from RST_ADR
////////////////////////////////////////////////////////////

localparam int PROG_LEN = 46;

// columns: four instruction words, then byte offset of the first and what they do
localparam mouse_pkg::word_t PROG [PROG_LEN] = '{
  32'h1234_50b7, 32'hffb0_0113, 32'h0070_0193, 32'h0031_0233, // 00 lui x1, x2=-5, x3=7, add
  32'h4021_82b3, 32'h0031_2333, 32'h0031_33b3, 32'h0031_4433, // 10 sub slt sltu xor
  32'h0031_64b3, 32'h0031_7533, 32'hffd1_2593, 32'hfff1_b613, // 20 or and slti sltiu
  32'hfff1_c693, 32'h0f01_7713, 32'h0051_8013, 32'h0080_07ef, // 30 xori andi x0 jal+8
  32'h0010_0813, 32'h0042_0463, 32'h0010_0893, 32'h0031_0463, // 40 skipped, beq t/n
  32'h0010_0913, 32'h0031_1463, 32'h0010_0993, 32'h0031_9463, // 50 bne t/n
  32'h0010_0a13, 32'h0031_4463, 32'h0010_0a93, 32'h0021_c463, // 60 blt t/n
  32'h0010_0b13, 32'h0021_d463, 32'h0010_0b93, 32'h0031_5463, // 70 bge t/n
  32'h0010_0c13, 32'h0021_e463, 32'h0010_0c93, 32'h0031_6463, // 80 bltu t/n
  32'h0010_0d13, 32'h0031_7463, 32'h0010_0d93, 32'h0021_f463, // 90 bgeu t/n
  32'h0010_0e13, 32'h7080_0e93, 32'h0050_8f33, 32'hffee_ae23, // a0 x29=0x708, add, sw -4
  32'hffce_af83, 32'h0000_0073                                 // b0 lw -4, ecall
};

// data words around the store target 0x704
localparam logic [9:0] DATA_WORD = 10'd448;

typedef struct packed {
  logic [63:0]      name; // up to 8 chars
  logic             mem;  // 1 memory word, 0 register
  logic [9:0]       idx;  // register number or word index
  mouse_pkg::word_t val;
} exp_row_t;

localparam int EXP_ROWS = 35;

// branch markers: taken skips the addi, so taken reads 0 and not taken reads 1
localparam exp_row_t EXP_TAB [EXP_ROWS] = '{
  '{"x0",       1'b0, 10'd0,  32'h0000_0000}, // write to x0 dropped
  '{"lui",      1'b0, 10'd1,  32'h1234_5000},
  '{"addi_neg", 1'b0, 10'd2,  32'hffff_fffb},
  '{"addi",     1'b0, 10'd3,  32'h0000_0007},
  '{"add",      1'b0, 10'd4,  32'h0000_0002}, // -5 + 7
  '{"sub",      1'b0, 10'd5,  32'h0000_000c}, // 7 - -5
  '{"slt",      1'b0, 10'd6,  32'h0000_0001},
  '{"sltu",     1'b0, 10'd7,  32'h0000_0000}, // -5 is large unsigned
  '{"xor",      1'b0, 10'd8,  32'hffff_fffc},
  '{"or",       1'b0, 10'd9,  32'hffff_ffff},
  '{"and",      1'b0, 10'd10, 32'h0000_0003},
  '{"slti",     1'b0, 10'd11, 32'h0000_0001}, // -5 < -3
  '{"sltiu",    1'b0, 10'd12, 32'h0000_0001}, // 7 < 0xffffffff
  '{"xori",     1'b0, 10'd13, 32'hffff_fff8},
  '{"andi",     1'b0, 10'd14, 32'h0000_00f0},
  '{"jal_link", 1'b0, 10'd15, 32'h0000_0040},
  '{"jal_skip", 1'b0, 10'd16, 32'h0000_0000},
  '{"beq_t",    1'b0, 10'd17, 32'h0000_0000},
  '{"beq_n",    1'b0, 10'd18, 32'h0000_0001},
  '{"bne_t",    1'b0, 10'd19, 32'h0000_0000},
  '{"bne_n",    1'b0, 10'd20, 32'h0000_0001},
  '{"blt_t",    1'b0, 10'd21, 32'h0000_0000},
  '{"blt_n",    1'b0, 10'd22, 32'h0000_0001},
  '{"bge_t",    1'b0, 10'd23, 32'h0000_0000},
  '{"bge_n",    1'b0, 10'd24, 32'h0000_0001},
  '{"bltu_t",   1'b0, 10'd25, 32'h0000_0000},
  '{"bltu_n",   1'b0, 10'd26, 32'h0000_0001},
  '{"bgeu_t",   1'b0, 10'd27, 32'h0000_0000},
  '{"bgeu_n",   1'b0, 10'd28, 32'h0000_0001},
  '{"base",     1'b0, 10'd29, 32'h0000_0708},
  '{"sum",      1'b0, 10'd30, 32'h1234_500c},
  '{"lw",       1'b0, 10'd31, 32'h1234_500c},
  '{"st_below", 1'b1, DATA_WORD,         32'h0000_0000},
  '{"sw",       1'b1, DATA_WORD + 10'd1, 32'h1234_500c},
  '{"st_above", 1'b1, DATA_WORD + 10'd2, 32'h0000_0000}
};

`endif

/* verif/mouse_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mouse_tb;

  localparam mouse_pkg::word_t RST_ADR   = 32'h0000_0000;
  localparam mouse_pkg::word_t GPR_ADR   = 32'h0000_0f80; // top 32 words
  localparam int unsigned      MEM_WORDS = 1024;

  `include "mouse_prog.svh"

  // up to four transfers per instruction, each stretched by stall
  localparam int RUN_LIMIT = PROG_LEN * 4 * 4 + 100;

  logic                clk = 1'b0;
  logic                rst;
  logic                stall = 1'b0;
  logic                stall_rand = 1'b0; // random throttling on
  logic                halted;
  logic                dbg_vld;
  mouse_pkg::bus_req_t dbg_req;
  mouse_pkg::word_t    dbg_rdt;
  int                  gpr_errs;
  int                  mem_errs;
  int                  run_idx;           // 0 no stall, 1 random stall
  logic                timed_out;         // core never reached ecall

  mouse_top #(
    .RST_ADR   (RST_ADR),
    .GPR_ADR   (GPR_ADR),
    .MEM_WORDS (MEM_WORDS)
  ) uut (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .halted  (halted),
    .dbg_vld (dbg_vld),
    .dbg_req (dbg_req),
    .dbg_rdt (dbg_rdt)
  );

  always #20 clk = ~clk; // 40 ns

  // about one cycle in three stalled
  always @(negedge clk) begin
    if (stall_rand) stall <= ($urandom % 3) == 0;
    else stall <= 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // debug port access
  ////////////////////////////////////////////////////////////

  task automatic write_word(input mouse_pkg::word_t addr, input mouse_pkg::word_t data);
    @(negedge clk);
    dbg_vld = 1'b1;
    dbg_req = '{wen: 1'b1, adr: addr, ben: 4'hf, wdt: data};
    @(negedge clk); // written at the posedge in between
    dbg_vld = 1'b0;
  endtask

  task automatic read_word(input mouse_pkg::word_t addr, output mouse_pkg::word_t data);
    @(negedge clk);
    dbg_vld = 1'b1;
    dbg_req = '{wen: 1'b0, adr: addr, ben: 4'hf, wdt: '0};
    @(negedge clk);
    dbg_vld = 1'b0;
    data    = dbg_rdt; // one cycle after the request
  endtask

  // clear gprs and data words, then the program
  task automatic load_program();
    for (int r = 0; r < 32; r++) begin
      write_word(GPR_ADR + 4 * r, '0);
    end
    for (int w = 0; w < 3; w++) begin
      write_word({20'd0, DATA_WORD, 2'b00} + 4 * w, '0);
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      write_word(RST_ADR + 4 * i, PROG[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // result checks
  ////////////////////////////////////////////////////////////

  task automatic check_gpr(input logic [63:0] name, input mouse_pkg::word_t exp,
                           input mouse_pkg::word_t act);
    if (act !== exp) begin
      $display("mismatch %0s (gpr, run %0d): expected %h, actual %h", name, run_idx, exp, act);
      gpr_errs++;
    end
  endtask

  task automatic check_mem(input logic [63:0] name, input mouse_pkg::word_t exp,
                           input mouse_pkg::word_t act);
    if (act !== exp) begin
      $display("mismatch %0s (mem, run %0d): expected %h, actual %h", name, run_idx, exp, act);
      mem_errs++;
    end
  endtask

  task automatic verify_results();
    mouse_pkg::word_t act;
    mouse_pkg::word_t addr;
    for (int i = 0; i < EXP_ROWS; i++) begin
      if (EXP_TAB[i].mem) begin
        addr = {20'd0, EXP_TAB[i].idx, 2'b00};
        read_word(addr, act);
        check_mem(EXP_TAB[i].name, EXP_TAB[i].val, act);
      end else begin
        addr = GPR_ADR + {20'd0, EXP_TAB[i].idx, 2'b00}; // gpr word
        read_word(addr, act);
        check_gpr(EXP_TAB[i].name, EXP_TAB[i].val, act);
      end
    end
  endtask

  // reset, load while in reset, run to ecall, check
  task automatic run_program(input logic rand_on);
    int cycles;
    rst        = 1'b1;
    stall_rand = rand_on;
    repeat (3) @(negedge clk);
    load_program();
    @(negedge clk);
    rst    = 1'b0;
    cycles = 0;
    while (!halted && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (cycles > RUN_LIMIT) begin
        $display("timeout: core did not halt (run %0d)", run_idx);
        timed_out = 1'b1;
      end
    end
    stall_rand = 1'b0;
    if (!timed_out) verify_results();
  endtask

  initial begin
    void'($urandom(32'h735));
    rst       = 1'b1;
    dbg_vld   = 1'b0;
    dbg_req   = '0;
    gpr_errs  = 0;
    mem_errs  = 0;
    run_idx   = 0;
    timed_out = 1'b0;
    run_program(1'b0);
    if (!timed_out) begin
      run_idx = 1;
      run_program(1'b1); // same table expected under back-pressure
    end
    $display("errors: gpr %0d, mem %0d, timeout %0d", gpr_errs, mem_errs, timed_out);
    if (gpr_errs + mem_errs == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+verif
hw/mouse_pkg.sv
hw/mouse_decode.sv
hw/mouse_execute.sv
hw/mouse_result.sv
hw/mouse_core.sv
hw/mouse_mem.sv
hw/mouse_top.sv
verif/mouse_tb.sv

/* run.sh */
#!/bin/sh
# build the mouse core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module mouse_tb -f files.f \
  --Mdir obj_dir -o mouse_sim

./obj_dir/mouse_sim | tee sim.log

# the testbench prints the fail line on any check error or timeout
if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
echo "simulation finished without failure"
exit 0
